//--- uart_cmd_params.svh
`ifndef UART_CMD_PARAMS_SVH
`define UART_CMD_PARAMS_SVH
`default_nettype none

// clock cycles per serial bit, kept small for simulation
`define UART_CLKS_PER_BIT 8

// start, 8 data, parity, stop
`define UART_FRAME_BITS 11

// bit times allowed before a reply start bit
`define UART_RX_TIMEOUT_BITS 24

`default_nettype wire
`endif

//--- uart_frame_pkg.sv
`include "uart_cmd_params.svh"
`default_nettype none

package uart_frame_pkg;

  // payload bits left after start, parity and stop
  localparam int UART_DATA_BITS = `UART_FRAME_BITS - 3;

  typedef logic [UART_DATA_BITS-1:0] uart_byte_t;

  typedef enum logic [2:0] {
    TX_IDLE,
    TX_START,
    TX_DATA,
    TX_PARITY,
    TX_STOP
  } tx_state_e;

  typedef enum logic [2:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_PARITY,
    RX_STOP
  } rx_state_e;

endpackage

`default_nettype wire

//--- uart_cmd_pkg.sv
`default_nettype none

package uart_cmd_pkg;

  import uart_frame_pkg::*;

  typedef enum logic {
    OP_WRITE = 1'b0,
    OP_READ  = 1'b1
  } cmd_op_e;

  // host command word, op in bit 15
  typedef struct packed {
    cmd_op_e    op;
    logic [6:0] addr;
    uart_byte_t wdata;
  } uart_cmd_t;

  // err sits above the returned byte
  typedef struct packed {
    logic       err;
    uart_byte_t data;
  } read_result_t;

  typedef enum logic [2:0] {
    C_IDLE,
    C_SEND_HDR,
    C_SEND_DATA,
    C_WAIT_REPLY,
    C_RECV
  } ctrl_state_e;

endpackage

`default_nettype wire

//--- uart_cmd_ifs.sv
`timescale 1ns/1ps
`default_nettype none

// controller to transmitter
interface uart_tx_if import uart_frame_pkg::*; ();
  logic       start;
  logic       busy;
  logic       done;
  uart_byte_t data;

  modport ctrl (output start, output data, input busy, input done);
  modport tx (input start, input data, output busy, output done);
endinterface

// receiver to controller
interface uart_rx_if import uart_frame_pkg::*; ();
  logic       enable;
  logic       start_seen;
  logic       valid;
  logic       parity_err;
  logic       frame_err;
  uart_byte_t data;

  modport ctrl (output enable, input start_seen, input valid, input data,
                input parity_err, input frame_err);
  modport rx (input enable, output start_seen, output valid, output data,
              output parity_err, output frame_err);
endinterface

`default_nettype wire

//--- uart_tx.sv
`timescale 1ns/1ps
`include "uart_cmd_params.svh"
`default_nettype none

module uart_tx import uart_frame_pkg::*; (
  input  logic  clk,
  input  logic  rst_n,
  uart_tx_if.tx tx_bus,
  output logic  tx
);

  localparam int CNT_W = $clog2(`UART_CLKS_PER_BIT);
  localparam int IDX_W = $clog2(UART_DATA_BITS);

  tx_state_e        state;
  logic [CNT_W-1:0] bit_cnt;
  logic [IDX_W-1:0] bit_idx;
  uart_byte_t       data_q;
  logic             bit_end;
  logic             parity;

  assign bit_end = (bit_cnt == CNT_W'(`UART_CLKS_PER_BIT - 1));
  // odd parity over the latched byte
  assign parity = ~^data_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state         <= TX_IDLE;
      bit_cnt       <= '0;
      bit_idx       <= '0;
      tx            <= 1'b1;
      tx_bus.busy   <= 1'b0;
      tx_bus.done   <= 1'b0;
    end else begin
      tx_bus.done <= 1'b0;
      if (state != TX_IDLE) begin
        bit_cnt <= bit_end ? '0 : bit_cnt + 1'b1;
      end
      case (state)
        TX_IDLE: begin
          if (tx_bus.start) begin
            state       <= TX_START;
            bit_cnt     <= '0;
            tx          <= 1'b0;
            tx_bus.busy <= 1'b1;
          end
        end
        TX_START: begin
          if (bit_end) begin
            state   <= TX_DATA;
            bit_idx <= '0;
            tx      <= data_q[0];
          end
        end
        TX_DATA: begin
          if (bit_end) begin
            if (bit_idx == IDX_W'(UART_DATA_BITS - 1)) begin
              state <= TX_PARITY;
              tx    <= parity;
            end else begin
              bit_idx <= bit_idx + 1'b1;
              tx      <= data_q[bit_idx + 1'b1];
            end
          end
        end
        TX_PARITY: begin
          if (bit_end) begin
            state <= TX_STOP;
            tx    <= 1'b1;
          end
        end
        TX_STOP: begin
          if (bit_end) begin
            state       <= TX_IDLE;
            tx_bus.busy <= 1'b0;
            tx_bus.done <= 1'b1;
          end
        end
        default: state <= TX_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == TX_IDLE && tx_bus.start) begin
      data_q <= tx_bus.data;
    end
  end

endmodule

`default_nettype wire

//--- uart_rx.sv
`timescale 1ns/1ps
`include "uart_cmd_params.svh"
`default_nettype none

module uart_rx import uart_frame_pkg::*; (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  rx,
  uart_rx_if.rx rx_bus
);

  localparam int CNT_W = $clog2(`UART_CLKS_PER_BIT);
  localparam int IDX_W = $clog2(UART_DATA_BITS);
  localparam int HALF  = `UART_CLKS_PER_BIT / 2;

  rx_state_e        state;
  logic [CNT_W-1:0] bit_cnt;
  logic [IDX_W-1:0] bit_idx;
  logic             rx_meta;
  logic             rx_sync;
  logic             rx_prev;
  logic             fall;
  logic             mid_start;
  logic             bit_end;
  logic             par_q;
  uart_byte_t       shreg;

  // two-flop synchronizer plus one for edge detect
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end else begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  assign fall      = rx_prev & ~rx_sync;
  assign mid_start = (bit_cnt == CNT_W'(HALF - 1));
  assign bit_end   = (bit_cnt == CNT_W'(`UART_CLKS_PER_BIT - 1));
  assign rx_bus.data = shreg;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state             <= RX_IDLE;
      bit_cnt           <= '0;
      bit_idx           <= '0;
      rx_bus.start_seen <= 1'b0;
      rx_bus.valid      <= 1'b0;
    end else begin
      rx_bus.start_seen <= 1'b0;
      rx_bus.valid      <= 1'b0;
      bit_cnt           <= bit_end ? '0 : bit_cnt + 1'b1;
      case (state)
        RX_IDLE: begin
          bit_cnt <= '0;
          if (rx_bus.enable && fall) begin
            state <= RX_START;
          end
        end
        RX_START: begin
          if (mid_start) begin
            bit_cnt <= '0;
            if (!rx_sync) begin
              state             <= RX_DATA;
              bit_idx           <= '0;
              rx_bus.start_seen <= 1'b1;
            end else begin
              // glitch, not a start bit
              state <= RX_IDLE;
            end
          end
        end
        RX_DATA: begin
          if (bit_end) begin
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == IDX_W'(UART_DATA_BITS - 1)) begin
              state <= RX_PARITY;
            end
          end
        end
        RX_PARITY: begin
          if (bit_end) begin
            state <= RX_STOP;
          end
        end
        RX_STOP: begin
          if (bit_end) begin
            state        <= RX_IDLE;
            rx_bus.valid <= 1'b1;
          end
        end
        default: state <= RX_IDLE;
      endcase
    end
  end

  // mid-bit sampling of payload, parity and stop
  always_ff @(posedge clk) begin
    if (state == RX_DATA && bit_end) begin
      shreg <= {rx_sync, shreg[UART_DATA_BITS-1:1]};
    end
    if (state == RX_PARITY && bit_end) begin
      par_q <= rx_sync;
    end
    if (state == RX_STOP && bit_end) begin
      rx_bus.parity_err <= ~(^{shreg, par_q});
      rx_bus.frame_err  <= ~rx_sync;
    end
  end

endmodule

`default_nettype wire

//--- uart_cmd_ctrl.sv
`timescale 1ns/1ps
`include "uart_cmd_params.svh"
`default_nettype none

module uart_cmd_ctrl
  import uart_frame_pkg::*;
  import uart_cmd_pkg::*;
(
  input  logic         clk,
  input  logic         rst_n,
  input  uart_cmd_t    cmd_in,
  input  logic         cmd_vld,
  output logic         cmd_rdy,
  output logic         read_rdy,
  output read_result_t read_data,
  uart_tx_if.ctrl      tx_bus,
  uart_rx_if.ctrl      rx_bus
);

  localparam int TMO_CYCLES = `UART_RX_TIMEOUT_BITS * `UART_CLKS_PER_BIT;
  localparam int TMO_W      = $clog2(TMO_CYCLES);

  ctrl_state_e      state;
  uart_cmd_t        cmd_q;
  uart_byte_t       hdr_byte;
  logic             hdr_pend;
  logic [TMO_W-1:0] tmo_cnt;
  logic             accept;
  logic             tmo_fire;
  logic             rx_fire;

  assign cmd_rdy  = (state == C_IDLE);
  assign accept   = cmd_vld && cmd_rdy;
  assign hdr_byte = uart_byte_t'({cmd_q.op, cmd_q.addr});

  // header goes first, wdata only in the data phase
  assign tx_bus.data   = (state == C_SEND_DATA) ? cmd_q.wdata : hdr_byte;
  assign rx_bus.enable = (state == C_WAIT_REPLY) || (state == C_RECV);

  // start_seen wins over an expiring counter
  assign tmo_fire = (state == C_WAIT_REPLY) && !rx_bus.start_seen &&
                    (tmo_cnt == TMO_W'(TMO_CYCLES - 1));
  assign rx_fire  = (state == C_RECV) && rx_bus.valid;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state        <= C_IDLE;
      hdr_pend     <= 1'b0;
      tmo_cnt      <= '0;
      tx_bus.start <= 1'b0;
      read_rdy     <= 1'b0;
    end else begin
      tx_bus.start <= 1'b0;
      read_rdy     <= tmo_fire || rx_fire;
      case (state)
        C_IDLE: begin
          if (accept) begin
            state    <= C_SEND_HDR;
            hdr_pend <= 1'b1;
          end
        end
        C_SEND_HDR: begin
          if (hdr_pend) begin
            if (!tx_bus.busy) begin
              tx_bus.start <= 1'b1;
              hdr_pend     <= 1'b0;
            end
          end else if (tx_bus.done) begin
            if (cmd_q.op == OP_READ) begin
              state   <= C_WAIT_REPLY;
              tmo_cnt <= '0;
            end else begin
              // back-to-back start keeps the 2-cycle gap
              state        <= C_SEND_DATA;
              tx_bus.start <= 1'b1;
            end
          end
        end
        C_SEND_DATA: begin
          if (tx_bus.done) begin
            state <= C_IDLE;
          end
        end
        C_WAIT_REPLY: begin
          if (rx_bus.start_seen) begin
            state <= C_RECV;
          end else if (tmo_fire) begin
            state <= C_IDLE;
          end else begin
            tmo_cnt <= tmo_cnt + 1'b1;
          end
        end
        C_RECV: begin
          if (rx_bus.valid) begin
            state <= C_IDLE;
          end
        end
        default: state <= C_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      cmd_q <= cmd_in;
    end
    if (tmo_fire) begin
      read_data <= '{err: 1'b1, data: '0};
    end else if (rx_fire) begin
      read_data <= '{err: rx_bus.parity_err | rx_bus.frame_err, data: rx_bus.data};
    end
  end

endmodule

`default_nettype wire

//--- uart_cmd_top.sv
`timescale 1ns/1ps
`default_nettype none

module uart_cmd_top import uart_cmd_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  logic [15:0] cmd_in,
  input  logic        cmd_vld,
  input  logic        rx,
  output logic        cmd_rdy,
  output logic        tx,
  output logic        read_rdy,
  output logic [8:0]  read_data
);

  uart_cmd_t    cmd_s;
  read_result_t rdata_s;

  uart_tx_if tx_bus ();
  uart_rx_if rx_bus ();

  assign cmd_s     = uart_cmd_t'(cmd_in);
  assign read_data = 9'(rdata_s);

  uart_cmd_ctrl u_ctrl (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_s),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .read_rdy  (read_rdy),
    .read_data (rdata_s),
    .tx_bus    (tx_bus.ctrl),
    .rx_bus    (rx_bus.ctrl)
  );

  uart_tx u_tx (
    .clk    (clk),
    .rst_n  (rst_n),
    .tx_bus (tx_bus.tx),
    .tx     (tx)
  );

  uart_rx u_rx (
    .clk    (clk),
    .rst_n  (rst_n),
    .rx     (rx),
    .rx_bus (rx_bus.rx)
  );

endmodule

`default_nettype wire

//--- uart_cmd_chk.sv
`timescale 1ns/1ps
`default_nettype none

module uart_cmd_chk import uart_cmd_pkg::*; (
  input logic        clk,
  input logic        rst_n,
  input logic [15:0] cmd_in,
  input logic        cmd_vld,
  input logic        cmd_rdy,
  input logic        tx,
  input logic        read_rdy
);

  uart_cmd_t cmd_s;
  logic      write_busy;

  assign cmd_s = uart_cmd_t'(cmd_in);

  // high from an accepted write until cmd_rdy returns
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      write_busy <= 1'b0;
    end else if (cmd_vld && cmd_rdy) begin
      write_busy <= (cmd_s.op == OP_WRITE);
    end else if (cmd_rdy) begin
      write_busy <= 1'b0;
    end
  end

  a_tx_idle: assert property (@(posedge clk) disable iff (!rst_n) cmd_rdy |-> tx)
    else $error("tx not idle while cmd_rdy is high");

  a_rdy_single: assert property (@(posedge clk) disable iff (!rst_n) read_rdy |=> !read_rdy)
    else $error("read_rdy high for two cycles in a row");

  a_accept_drop: assert property (@(posedge clk) disable iff (!rst_n)
                                  (cmd_vld && cmd_rdy) |=> !cmd_rdy)
    else $error("cmd_rdy still high after an accepted command");

  a_no_rdy_on_write: assert property (@(posedge clk) disable iff (!rst_n)
                                      read_rdy |-> !write_busy)
    else $error("read_rdy during a write");

endmodule

bind uart_cmd_top uart_cmd_chk chk (
  .clk      (clk),
  .rst_n    (rst_n),
  .cmd_in   (cmd_in),
  .cmd_vld  (cmd_vld),
  .cmd_rdy  (cmd_rdy),
  .tx       (tx),
  .read_rdy (read_rdy)
);

`default_nettype wire

//--- tb_uart_cmd.sv
`timescale 1ns/1ps
`include "uart_cmd_params.svh"
`default_nettype none

module tb_uart_cmd
  import uart_frame_pkg::*;
  import uart_cmd_pkg::*;
();

  localparam int CPB       = `UART_CLKS_PER_BIT;
  localparam int N_CMDS    = 60;
  // twice three frames plus the longest reply wait per command
  localparam int WATCHDOG  = N_CMDS * (3 * `UART_FRAME_BITS + 34) * CPB * 2;
  localparam int CMD_LIMIT = (2 * `UART_FRAME_BITS + `UART_RX_TIMEOUT_BITS + 4) * CPB;

  typedef enum int {REPLY_NONE, REPLY_GOOD, REPLY_BAD_PAR, REPLY_BAD_STOP} reply_e;

  logic        clk;
  logic        rst_n;
  logic [15:0] cmd_in;
  logic        cmd_vld;
  logic        rx;
  logic        cmd_rdy;
  logic        tx;
  logic        read_rdy;
  logic [8:0]  read_data;

  int cyc = 0;
  int rdy_pulses = 0;
  int err_cnt = 0;
  int tests_ok = 0;
  int tests_bad = 0;

  uart_cmd_top dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .rx        (rx),
    .cmd_rdy   (cmd_rdy),
    .tx        (tx),
    .read_rdy  (read_rdy),
    .read_data (read_data)
  );

  initial clk = 1'b0;
  always #20 clk = ~clk;

  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (cyc >= WATCHDOG) begin
      $display("run stopped by the watchdog after %0d cycles", cyc);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  always @(negedge clk) begin
    if (read_rdy === 1'b1) begin
      rdy_pulses++;
    end
  end

  task automatic flag_error(input string what);
    $display("%s at cycle %0d", what, cyc);
    err_cnt++;
  endtask

  task automatic check_frame(input string name, input uart_byte_t got, input uart_byte_t exp);
    if (got !== exp) begin
      $display("ERROR: %s got %02h expected %02h", name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_read(input read_result_t got, input read_result_t exp);
    if (got !== exp) begin
      $display("ERROR: read_data got %03h expected %03h", got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("ERROR: %s got %0h expected %0h at cycle %0d", name, got, exp, cyc);
      err_cnt++;
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) begin
      $display("ERROR: %s got %0h expected %0h", name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic log_test(input string name, input int errs_before);
    if (err_cnt == errs_before) begin
      tests_ok++;
      $display("%s: ok", name);
    end else begin
      tests_bad++;
      $display("%s: failed", name);
    end
  endtask

  // parity bit that leaves payload plus parity with an odd count of ones
  function automatic logic odd_parity(input uart_byte_t b);
    return ($countones(b) % 2) == 0;
  endfunction

  function automatic read_result_t expect_read(input reply_e reply, input uart_byte_t b);
    read_result_t r;
    r.err  = (reply != REPLY_GOOD);
    r.data = (reply == REPLY_NONE) ? 8'h00 : b;
    return r;
  endfunction

  // samples one tx frame at mid-bit
  task automatic decode_frame(output uart_byte_t b, output int start_cyc);
    int i;
    @(negedge clk);
    while (tx !== 1'b0) @(negedge clk);
    start_cyc = cyc;
    repeat (CPB / 2) @(negedge clk);
    check_bit("tx start bit", tx, 1'b0);
    for (i = 0; i < 8; i++) begin
      repeat (CPB) @(negedge clk);
      b[i] = tx;
    end
    repeat (CPB) @(negedge clk);
    check_bit("tx parity bit", tx, odd_parity(b));
    repeat (CPB) @(negedge clk);
    check_bit("tx stop bit", tx, 1'b1);
  endtask

  task automatic send_frame(input uart_byte_t b, input bit bad_par, input bit bad_stop);
    logic [10:0] bits;
    int i;
    bits = {~bad_stop, odd_parity(b) ^ bad_par, b, 1'b0};
    for (i = 0; i < 11; i++) begin
      @(posedge clk);
      #1 rx = bits[i];
      repeat (CPB - 1) @(posedge clk);
    end
    @(posedge clk);
    #1 rx = 1'b1;
  endtask

  task automatic play_slave(input uart_cmd_t cmd, input reply_e reply, input uart_byte_t rbyte,
                            output int hdr_start);
    uart_byte_t got;
    int data_start;
    decode_frame(got, hdr_start);
    // op bit and address fill the upper byte of the command word
    check_frame("tx header byte", got, cmd[15:8]);
    if (cmd.op == OP_WRITE) begin
      decode_frame(got, data_start);
      check_frame("tx data byte", got, cmd.wdata);
      // full header frame and two idle cycles
      check_count("tx data frame offset", data_start - hdr_start, `UART_FRAME_BITS * CPB + 2);
    end else if (reply != REPLY_NONE) begin
      @(posedge clk);
      repeat ($urandom_range(1, 10) * CPB) @(posedge clk);
      send_frame(rbyte, reply == REPLY_BAD_PAR, reply == REPLY_BAD_STOP);
    end
  endtask

  task automatic poke_busy();
    int k;
    for (k = 0; k < 3; k++) begin
      repeat ($urandom_range(1, 20)) @(posedge clk);
      #1;
      cmd_in  = 16'($urandom);
      cmd_vld = 1'b1;
      @(posedge clk);
      #1;
      cmd_vld = 1'b0;
    end
  endtask

  task automatic run_cmd(input int n, input uart_cmd_t cmd, input reply_e reply, input bit strobe);
    uart_byte_t   rbyte;
    read_result_t got;
    int           acc_cyc;
    int           hdr_start;
    int           pulses_before;
    int           errs_before;
    int           waited;
    bit           is_read;
    bit           idle_ok;
    string        kind;
    is_read       = (cmd.op == OP_READ);
    kind          = is_read ? reply.name() : "WRITE";
    rbyte         = uart_byte_t'($urandom);
    got           = '0;
    acc_cyc       = 0;
    errs_before   = err_cnt;
    pulses_before = rdy_pulses;
    fork
      begin
        @(posedge clk);
        #1;
        cmd_in  = cmd;
        cmd_vld = 1'b1;
        @(posedge clk);
        #1;
        acc_cyc = cyc;
        cmd_vld = 1'b0;
        @(negedge clk);
        check_bit("cmd_rdy after accept", cmd_rdy, 1'b0);
        if (strobe) begin
          poke_busy();
        end
        waited = 0;
        @(negedge clk);
        while (((is_read ? read_rdy : cmd_rdy) !== 1'b1) && waited < CMD_LIMIT) begin
          @(negedge clk);
          waited++;
        end
        if (waited >= CMD_LIMIT) begin
          flag_error("command did not complete in time");
        end else if (is_read) begin
          got = read_result_t'(read_data);
          check_bit("cmd_rdy with read_rdy", cmd_rdy, 1'b1);
        end
      end
      play_slave(cmd, reply, rbyte, hdr_start);
    join
    check_count("tx header start delay", hdr_start - acc_cyc, 2);
    if (is_read) begin
      check_read(got, expect_read(reply, rbyte));
    end
    // no extra frame once the command is over
    idle_ok = 1'b1;
    repeat (2 * CPB) begin
      @(negedge clk);
      if (tx !== 1'b1 || cmd_rdy !== 1'b1) begin
        idle_ok = 1'b0;
      end
    end
    if (!idle_ok) begin
      flag_error("tx or cmd_rdy left idle after the command finished");
    end
    #1;
    check_count("read_rdy pulses", rdy_pulses - pulses_before, is_read ? 1 : 0);
    log_test($sformatf("cmd %0d %s addr %02h strobes %0d", n, kind, cmd.addr, strobe),
             errs_before);
  endtask

  initial begin
    uart_cmd_t cmd;
    reply_e    reply;
    bit        strobe;
    int        n;
    int        errs_before;
    int        seed_ret;
    seed_ret = $urandom(32'hc9de_ec84);
    rst_n    = 1'b0;
    cmd_in   = '0;
    cmd_vld  = 1'b0;
    rx       = 1'b1;
    repeat (5) @(posedge clk);
    #1;
    rst_n = 1'b1;

    errs_before = err_cnt;
    repeat (4 * CPB) begin
      @(negedge clk);
      check_bit("tx", tx, 1'b1);
      check_bit("cmd_rdy", cmd_rdy, 1'b1);
      check_bit("read_rdy", read_rdy, 1'b0);
    end
    log_test("reset idle state", errs_before);

    for (n = 0; n < N_CMDS; n++) begin
      cmd    = uart_cmd_t'(16'($urandom));
      cmd.op = (n % 5 == 0) ? OP_WRITE : OP_READ;
      case (n % 5)
        1: reply = REPLY_GOOD;
        2: reply = REPLY_BAD_PAR;
        3: reply = REPLY_BAD_STOP;
        default: reply = REPLY_NONE;
      endcase
      strobe = 1'($urandom_range(0, 1));
      run_cmd(n, cmd, reply, strobe);
    end

    $display("tests passed %0d, tests failed %0d, check errors %0d",
             tests_ok, tests_bad, err_cnt);
    if (tests_bad == 0 && err_cnt == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- uart_cmd.f
+incdir+.
uart_frame_pkg.sv
uart_cmd_pkg.sv
uart_cmd_ifs.sv
uart_tx.sv
uart_rx.sv
uart_cmd_ctrl.sv
uart_cmd_top.sv
uart_cmd_chk.sv
tb_uart_cmd.sv

//--- run_sim.sh
#!/bin/sh
# build and run the uart_cmd testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f uart_cmd.f --top-module tb_uart_cmd -Mdir obj_dir -o sim_uart_cmd
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/sim_uart_cmd +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "RESULT: FAIL" "$LOG"; then
  exit 1
fi
exit 0
